// ==== arcade_board.f ====
design/board_pkg.sv
design/ps2_pkg.sv
design/ps2_receiver.sv
design/key_decoder.sv
design/joy_splitter.sv
design/reset_sequencer.sv
design/arcade_board_top.sv
verif/tb_arcade_board.sv

// ==== design/arcade_board_top.sv ====
// board adaptation top
// keyboard, joystick and reset handling in front of the game core
`timescale 1ns/1ps

module arcade_board_top
  import board_pkg::*;
  import ps2_pkg::*;
#(
  parameter int joy_type = 1,
  parameter int por_w    = por_w_default
) (
  input  logic                 pclk,
  input  logic                 pll_lckd,
  input  logic                 ps2_clk,
  input  logic                 ps2_data,
  input  logic [joy_w-1:0]     jjoy,
  input  logic [5:0]           joystick,
  input  logic                 jtest,
  input  logic                 jservice,
  output logic                 joy_select,
  output logic [joy_w-1:0]     joystick1,
  output logic [joy_w-1:0]     joystick2,
  output logic [scan_sw_w-1:0] scan_sw,
  output logic                 led,
  output logic                 core_reset,
  output logic                 reboot
);

  ps2_byte_t scan_code;
  logic      code_valid;
  logic      parity_err;
  logic      reset_key;
  logic      master_reset;

  ////////////////////////////////
  // keyboard path
  ////////////////////////////////

  // bad frames stop here, only good codes reach the decoder
  ps2_receiver u_ps2_receiver (
    .pclk       (pclk),
    .pll_lckd   (pll_lckd),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .scan_code  (scan_code),
    .code_valid (code_valid),
    .parity_err (parity_err)
  );

  key_decoder u_key_decoder (
    .pclk         (pclk),
    .pll_lckd     (pll_lckd),
    .scan_code    (scan_code),
    .code_valid   (code_valid),
    .reset_key    (reset_key),
    .master_reset (master_reset),
    .scan_sw      (scan_sw),
    .led          (led)
  );

  ////////////////////////////////
  // controls and reset
  ////////////////////////////////

  joy_splitter #(
    .joy_type (joy_type)
  ) u_joy_splitter (
    .pclk       (pclk),
    .pll_lckd   (pll_lckd),
    .jjoy       (jjoy),
    .joystick   (joystick),
    .joy_select (joy_select),
    .joystick1  (joystick1),
    .joystick2  (joystick2)
  );

  reset_sequencer #(
    .por_w (por_w)
  ) u_reset_sequencer (
    .pclk         (pclk),
    .pll_lckd     (pll_lckd),
    .reset_key    (reset_key),
    .master_reset (master_reset),
    .jtest        (jtest),
    .jservice     (jservice),
    .core_reset   (core_reset),
    .reboot       (reboot)
  );

endmodule

// ==== design/board_pkg.sv ====
// board constants
// joystick word layout, switch count and power-on delay width
package board_pkg;

  ////////////////////////////////
  // joystick word
  ////////////////////////////////

  // one player word on the jamma bus
  localparam int joy_w = 8;

  // start button position
  // bits 5..0 are directions and fire, bit 6 unused and reads one
  localparam int joy_fire_hi = 7;

  ////////////////////////////////
  // board controls
  ////////////////////////////////

  // toggle switches driven from the keyboard
  localparam int scan_sw_w = 4;

  // power-on counter width, delay is 2**por_w cycles
  localparam int por_w_default = 8;

endpackage

// ==== design/joy_splitter.sv ====
// jamma joystick splitter
// reads two players over one muxed 8-bit bus, or the local stick only
`timescale 1ns/1ps

module joy_splitter
  import board_pkg::*;
#(
  parameter int joy_type = 1
) (
  input  logic             pclk,
  input  logic             pll_lckd,
  input  logic [joy_w-1:0] jjoy,
  input  logic [5:0]       joystick,
  output logic             joy_select,
  output logic [joy_w-1:0] joystick1,
  output logic [joy_w-1:0] joystick2
);

  // local stick widened, start and spare bits read one
  logic [joy_w-1:0] local_joy;

  assign local_joy[5:0]             = joystick;
  assign local_joy[joy_fire_hi:6]   = '1;

  generate
    if (joy_type == 1) begin : g_jamma
      // select low reads p1, high reads p2
      always_ff @(posedge pclk or negedge pll_lckd) begin
        if (!pll_lckd) begin
          joy_select <= 1'b0;
          joystick1  <= '1;
          joystick2  <= '1;
        end else begin
          joy_select <= ~joy_select;
          if (!joy_select) begin
            joystick1 <= jjoy & local_joy;
          end else begin
            joystick2 <= jjoy;
          end
        end
      end

      a_select_toggle : assert property (@(posedge pclk) disable iff (!pll_lckd)
        1'b1 |=> joy_select != $past(joy_select));
    end else begin : g_local
      // no jamma bus, p2 idles released
      assign joystick1  = local_joy;
      assign joystick2  = '1;
      assign joy_select = 1'b0;
    end
  endgenerate

endmodule

// ==== design/key_decoder.sv ====
// keyboard decoder
// tracks break/extended prefixes, held keys, toggle switches
// and the ctrl+alt+backspace reboot chord
`timescale 1ns/1ps

module key_decoder
  import ps2_pkg::*;
  import board_pkg::*;
(
  input  logic                 pclk,
  input  logic                 pll_lckd,
  input  ps2_byte_t            scan_code,
  input  logic                 code_valid,
  output logic                 reset_key,
  output logic                 master_reset,
  output logic [scan_sw_w-1:0] scan_sw,
  output logic                 led
);

  logic brk_pend;
  logic ext_pend;
  logic ctrl_held;
  logic alt_held;

  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      brk_pend     <= 1'b0;
      ext_pend     <= 1'b0;
      ctrl_held    <= 1'b0;
      alt_held     <= 1'b0;
      reset_key    <= 1'b0;
      master_reset <= 1'b0;
      scan_sw      <= '0;
    end else begin
      master_reset <= 1'b0;
      if (code_valid) begin
        if (scan_code == code_break) begin
          brk_pend <= 1'b1;
        end else if (scan_code == code_ext) begin
          // ext then break still leaves break pending
          ext_pend <= 1'b1;
        end else begin
          // any real code consumes both prefixes
          brk_pend <= 1'b0;
          ext_pend <= 1'b0;
          if (ext_pend) begin
            // right-hand and cursor keys, not used here
          end else if (brk_pend) begin
            // release, switches keep their state
            case (scan_code)
              code_f3:    reset_key <= 1'b0;
              code_lctrl: ctrl_held <= 1'b0;
              code_lalt:  alt_held  <= 1'b0;
              default: ;
            endcase
          end else begin
            // make
            case (scan_code)
              code_f3:     reset_key  <= 1'b1;
              code_lctrl:  ctrl_held  <= 1'b1;
              code_lalt:   alt_held   <= 1'b1;
              code_scroll: scan_sw[0] <= ~scan_sw[0];
              code_f9:     scan_sw[1] <= ~scan_sw[1];
              code_f10:    scan_sw[2] <= ~scan_sw[2];
              code_f11:    scan_sw[3] <= ~scan_sw[3];
              code_bksp:   master_reset <= ctrl_held && alt_held;
              default: ;
            endcase
          end
        end
      end
    end
  end

  // board led mirrors switch 1
  assign led = scan_sw[1];

  // reboot only from a decoded code with both modifiers down
  a_chord : assert property (@(posedge pclk) disable iff (!pll_lckd)
    master_reset |-> ctrl_held && alt_held && $past(code_valid));

endmodule

// ==== design/ps2_pkg.sv ====
// ps/2 keyboard definitions
// frame length, scan code type and the set-2 codes the decoder acts on
package ps2_pkg;

  // start + 8 data + parity + stop
  localparam int ps2_frame_bits = 11;

  typedef logic [7:0] ps2_byte_t;

  // prefixes
  localparam ps2_byte_t code_break = 8'hf0;
  localparam ps2_byte_t code_ext   = 8'he0;

  // core reset key
  localparam ps2_byte_t code_f3 = 8'h04;

  // switch keys, scroll lock = scandoubler enable, f9 = led
  localparam ps2_byte_t code_scroll = 8'h7e;
  localparam ps2_byte_t code_f9     = 8'h01;
  localparam ps2_byte_t code_f10    = 8'h09;
  localparam ps2_byte_t code_f11    = 8'h78;

  // ctrl+alt+backspace reboot chord
  localparam ps2_byte_t code_lctrl = 8'h14;
  localparam ps2_byte_t code_lalt  = 8'h11;
  localparam ps2_byte_t code_bksp  = 8'h66;

endpackage

// ==== design/ps2_receiver.sv ====
// ps/2 receiver
// syncs and filters the keyboard lines, shifts in 11-bit frames
// and flags each byte as valid or as a parity/framing error
`timescale 1ns/1ps

module ps2_receiver
  import ps2_pkg::*;
#(
  parameter int filt_len     = 4,
  parameter int idle_limit_w = 11
) (
  input  logic      pclk,
  input  logic      pll_lckd,
  input  logic      ps2_clk,
  input  logic      ps2_data,
  output ps2_byte_t scan_code,
  output logic      code_valid,
  output logic      parity_err
);

  localparam int cnt_w = $clog2(ps2_frame_bits);

  logic [1:0]                clk_sync;
  logic [1:0]                data_sync;
  logic [filt_len-1:0]       clk_hist;
  logic                      filt_clk;
  logic                      clk_fall;
  logic [cnt_w-1:0]          bit_cnt;
  logic [ps2_frame_bits-1:0] frame;
  logic [ps2_frame_bits-1:0] frame_next;
  logic [idle_limit_w-1:0]   idle_cnt;
  logic                      last_bit;
  logic                      frame_ok;

  //////////////////////////////
  // line sync and clock filter
  //////////////////////////////

  // both lines idle high
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      clk_sync  <= '1;
      data_sync <= '1;
      clk_hist  <= '1;
      filt_clk  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_hist  <= {clk_hist[filt_len-2:0], clk_sync[1]};
      // filtered clock only moves when all samples agree
      if (clk_hist == '1) begin
        filt_clk <= 1'b1;
      end else if (clk_hist == '0) begin
        filt_clk <= 1'b0;
      end
    end
  end

  // act on the cycle the filtered clock drops
  assign clk_fall = filt_clk && (clk_hist == '0);

  //////////////////////////////
  // frame assembly
  //////////////////////////////

  // lsb first, new bit enters at the top
  assign frame_next = {data_sync[1], frame[ps2_frame_bits-1:1]};
  assign last_bit   = (bit_cnt == cnt_w'(ps2_frame_bits - 1));

  // start low, odd parity over data+parity, stop high
  assign frame_ok = !frame_next[0] && (^frame_next[9:1]) &&
                    frame_next[ps2_frame_bits-1];

  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      bit_cnt    <= '0;
      idle_cnt   <= '0;
      code_valid <= 1'b0;
      parity_err <= 1'b0;
    end else begin
      // strobes last one cycle
      code_valid <= 1'b0;
      parity_err <= 1'b0;
      if (clk_fall) begin
        idle_cnt <= '0;
        if (last_bit) begin
          bit_cnt    <= '0;
          code_valid <= frame_ok;
          parity_err <= !frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else if (bit_cnt != '0) begin
        // partial frame and no clock for too long, drop it
        if (idle_cnt == '1) begin
          bit_cnt  <= '0;
          idle_cnt <= '0;
        end else begin
          idle_cnt <= idle_cnt + 1'b1;
        end
      end
    end
  end

  // frame shifter and captured byte
  always_ff @(posedge pclk) begin
    if (clk_fall) begin
      frame <= frame_next;
    end
    if (clk_fall && last_bit) begin
      scan_code <= frame_next[8:1];
    end
  end

  // a strobe comes one cycle after the filtered clock drops
  // never both at once, each one cycle wide
  a_strobe_excl : assert property (@(posedge pclk) disable iff (!pll_lckd)
    (code_valid || parity_err) |-> !(code_valid && parity_err) && $fell(filt_clk));
  a_valid_pulse : assert property (@(posedge pclk) disable iff (!pll_lckd)
    code_valid |=> !code_valid);
  a_err_pulse : assert property (@(posedge pclk) disable iff (!pll_lckd)
    parity_err |=> !parity_err);

endmodule

// ==== design/reset_sequencer.sv ====
// reset sequencer
// power-on hold of the core, reset key and test button merge,
// one-cycle reboot request
`timescale 1ns/1ps

module reset_sequencer
  import board_pkg::*;
#(
  parameter int por_w = por_w_default
) (
  input  logic pclk,
  input  logic pll_lckd,
  input  logic reset_key,
  input  logic master_reset,
  input  logic jtest,
  input  logic jservice,
  output logic core_reset,
  output logic reboot
);

  logic [por_w-1:0] por_cnt;
  logic             por_done;
  logic             por_last;
  logic             jservice_q;
  logic             svc_fall;

  // final count of the power-on window
  assign por_last = (por_cnt == '1);

  // service button pressed, active low
  assign svc_fall = jservice_q && !jservice;

  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      por_cnt    <= '0;
      por_done   <= 1'b0;
      core_reset <= 1'b1;
      jservice_q <= 1'b1;
      reboot     <= 1'b0;
    end else begin
      // count up once, then hold
      if (!por_done && !por_last) begin
        por_cnt <= por_cnt + 1'b1;
      end
      por_done <= por_done | por_last;

      // held through 2**por_w cycles, then key and test button
      core_reset <= !(por_done || por_last) || reset_key || !jtest;

      jservice_q <= jservice;
      reboot     <= master_reset || svc_fall;
    end
  end

  // multiboot wants a single pulse
  a_reboot_pulse : assert property (@(posedge pclk) disable iff (!pll_lckd)
    reboot |=> !reboot);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the board testbench with verilator, pass is judged from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f arcade_board.f --top-module tb_arcade_board \
  -Mdir obj_dir -o tb_arcade_board \
  && ./obj_dir/tb_arcade_board | tee sim.log \
  || echo "build or simulation did not complete"
grep -q "^NO ERRORS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== verif/tb_arcade_board.sv ====
// board adaptation testbench
// drives ps/2 frames, jamma joystick words and the test/service buttons
// and checks the top level against a cycle model with concurrent assertions
`timescale 1ns/1ps

module tb_arcade_board
  import ps2_pkg::*;
  import board_pkg::*;
();

  localparam int tb_por_w   = 8;
  localparam int por_cycles = 1 << tb_por_w;
  // ps/2 clock half period in pclk cycles
  localparam int half_bit     = 20;
  localparam int frame_cycles = 2 * half_bit * ps2_frame_bits;
  localparam int frame_gap    = 20;
  localparam int strobe_wait  = 64;
  // 16 frames, power-on, then slack for gaps, joystick and button tests
  localparam int max_frames     = 16;
  localparam int por_budget     = 300;
  localparam int slack_cycles   = 4660;
  localparam int timeout_cycles = max_frames * frame_cycles + por_budget + slack_cycles;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;

  logic                 pclk;
  logic                 pll_lckd;
  logic                 ps2_clk;
  logic                 ps2_data;
  logic [joy_w-1:0]     jjoy;
  logic [5:0]           joystick;
  logic                 jtest;
  logic                 jservice;
  logic                 joy_select;
  logic [joy_w-1:0]     joystick1;
  logic [joy_w-1:0]     joystick2;
  logic [scan_sw_w-1:0] scan_sw;
  logic                 led;
  logic                 core_reset;
  logic                 reboot;

  // stimulus side, what the current frame should do
  ps2_byte_t            sent_code;
  logic                 frame_good;
  logic [scan_sw_w-1:0] want_sw;
  logic                 want_rk;
  logic                 want_mr;

  // cycle model
  int                   since_rel;
  int                   strobes;
  logic [scan_sw_w-1:0] sw_exp;
  logic                 rk_exp;
  logic                 mr_exp;
  logic                 core_exp;
  logic                 svc_q;
  logic                 reboot_exp;
  logic                 sel_exp;
  logic [joy_w-1:0]     joy1_exp;
  logic [joy_w-1:0]     joy2_exp;

  logic [31:0] lfsr = 32'h8f3b_9d7b;
  int          cyc = 0;
  int          err_cnt = 0;
  int          test_err_base = 0;
  int          tests_pass = 0;
  int          tests_fail = 0;

  arcade_board_top #(
    .joy_type (1),
    .por_w    (tb_por_w)
  ) u_dut (
    .pclk       (pclk),
    .pll_lckd   (pll_lckd),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .jjoy       (jjoy),
    .joystick   (joystick),
    .jtest      (jtest),
    .jservice   (jservice),
    .joy_select (joy_select),
    .joystick1  (joystick1),
    .joystick2  (joystick2),
    .scan_sw    (scan_sw),
    .led        (led),
    .core_reset (core_reset),
    .reboot     (reboot)
  );

  always #2 pclk = ~pclk;

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    int         i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
    take_bits = v;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] got_v);
    err_cnt++;
    $display("ERR %s expected %0h actual %0h at %0t", name, exp_v, got_v, $time);
  endtask

  task automatic note_failure(input string msg);
    err_cnt++;
    $display("at %0t: %s", $time, msg);
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err_base) begin
      tests_pass++;
      $display("test %s: pass", name);
    end else begin
      tests_fail++;
      $display("test %s: fail, %0d failed checks", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  // keyboard frame, lsb first, device sets data while clock is high
  task automatic send_frame(input ps2_byte_t code, input logic good,
                            input logic [scan_sw_w-1:0] sw_after,
                            input logic rk_after, input logic mr_after);
    logic [ps2_frame_bits-1:0] bits;
    int                        start_strobes;
    int                        waited;
    int                        i;
    sent_code     = code;
    frame_good    = good;
    want_sw       = sw_after;
    want_rk       = rk_after;
    want_mr       = mr_after;
    // stop, odd parity (or its inverse), data, start
    bits          = {1'b1, good ? ~^code : ^code, code, 1'b0};
    start_strobes = strobes;
    for (i = 0; i < ps2_frame_bits; i++) begin
      ps2_data = bits[i];
      repeat (half_bit) @(negedge pclk);
      ps2_clk = 1'b0;
      repeat (half_bit) @(negedge pclk);
      ps2_clk = 1'b1;
    end
    waited = 0;
    while (strobes == start_strobes && waited < strobe_wait) begin
      @(negedge pclk);
      waited++;
    end
    if (strobes == start_strobes) begin
      note_failure("no code_valid or parity_err after a keyboard frame");
    end
    ps2_data = 1'b1;
    repeat (frame_gap) @(negedge pclk);
    want_mr = 1'b0;
  endtask

  //////////////////////////////
  // expected behaviour
  //////////////////////////////

  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      since_rel  <= 0;
      strobes    <= 0;
      sw_exp     <= '0;
      rk_exp     <= 1'b0;
      mr_exp     <= 1'b0;
      core_exp   <= 1'b1;
      svc_q      <= 1'b1;
      reboot_exp <= 1'b0;
      sel_exp    <= 1'b0;
      joy1_exp   <= '1;
      joy2_exp   <= '1;
    end else begin
      since_rel <= since_rel + 1;
      if (u_dut.code_valid || u_dut.parity_err) begin
        strobes <= strobes + 1;
      end
      // decoded state moves the cycle after code_valid
      if (u_dut.code_valid) begin
        sw_exp <= want_sw;
        rk_exp <= want_rk;
      end
      mr_exp <= u_dut.code_valid && want_mr;
      // core held for 2**por_w cycles, then key or test button
      core_exp   <= (since_rel < por_cycles - 1) || rk_exp || !jtest;
      svc_q      <= jservice;
      reboot_exp <= mr_exp || (svc_q && !jservice);
      sel_exp    <= !sel_exp;
      if (!sel_exp) begin
        joy1_exp <= jjoy & {2'b11, joystick};
      end else begin
        joy2_exp <= jjoy;
      end
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  a_por_hold : assert property (@(posedge pclk) disable iff (!pll_lckd)
    since_rel < por_cycles |-> core_reset)
    else note_failure("core_reset dropped inside the power-on delay");
  a_por_release : assert property (@(posedge pclk) disable iff (!pll_lckd)
    since_rel == por_cycles |-> !core_reset)
    else note_failure("core_reset still high one cycle after the power-on delay");
  a_core_reset : assert property (@(posedge pclk) disable iff (!pll_lckd)
    core_reset == core_exp)
    else report_mismatch("core_reset", 32'($sampled(core_exp)),
                         32'($sampled(core_reset)));
  a_select : assert property (@(posedge pclk) disable iff (!pll_lckd)
    joy_select == sel_exp)
    else report_mismatch("joy_select", 32'($sampled(sel_exp)),
                         32'($sampled(joy_select)));
  a_joy1 : assert property (@(posedge pclk) disable iff (!pll_lckd)
    joystick1 == joy1_exp)
    else report_mismatch("joystick1", 32'($sampled(joy1_exp)),
                         32'($sampled(joystick1)));
  a_joy2 : assert property (@(posedge pclk) disable iff (!pll_lckd)
    joystick2 == joy2_exp)
    else report_mismatch("joystick2", 32'($sampled(joy2_exp)),
                         32'($sampled(joystick2)));
  a_scan_sw : assert property (@(posedge pclk) disable iff (!pll_lckd)
    scan_sw == sw_exp)
    else report_mismatch("scan_sw", 32'($sampled(sw_exp)),
                         32'($sampled(scan_sw)));
  a_led : assert property (@(posedge pclk) disable iff (!pll_lckd)
    led == sw_exp[1])
    else report_mismatch("led", 32'($sampled(sw_exp[1])), 32'($sampled(led)));
  a_code_good : assert property (@(posedge pclk) disable iff (!pll_lckd)
    u_dut.code_valid |-> frame_good)
    else note_failure("code_valid after a frame with bad parity");
  a_code_value : assert property (@(posedge pclk) disable iff (!pll_lckd)
    u_dut.code_valid |-> u_dut.scan_code == sent_code)
    else report_mismatch("scan_code", 32'($sampled(sent_code)),
                         32'($sampled(u_dut.scan_code)));
  a_perr : assert property (@(posedge pclk) disable iff (!pll_lckd)
    u_dut.parity_err |-> !frame_good)
    else note_failure("parity_err on a frame with good parity");
  a_reboot : assert property (@(posedge pclk) disable iff (!pll_lckd)
    reboot == reboot_exp)
    else report_mismatch("reboot", 32'($sampled(reboot_exp)),
                         32'($sampled(reboot)));

  // hang guard
  always @(posedge pclk) begin
    cyc <= cyc + 1;
    if (cyc >= timeout_cycles) begin
      $display("timeout after %0d cycles, tests did not finish", cyc);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin
    int         waited;
    logic [7:0] rnd;
    pclk       = 1'b0;
    pll_lckd   = 1'b0;
    ps2_clk    = 1'b1;
    ps2_data   = 1'b1;
    jjoy       = '1;
    joystick   = '1;
    jtest      = 1'b1;
    jservice   = 1'b1;
    sent_code  = '0;
    frame_good = 1'b1;
    want_sw    = '0;
    want_rk    = 1'b0;
    want_mr    = 1'b0;
    repeat (4) @(negedge pclk);
    pll_lckd = 1'b1;

    // power-on, wait for the core to leave reset
    waited = 0;
    while (core_reset && waited < por_cycles + 16) begin
      @(negedge pclk);
      waited++;
    end
    if (core_reset) begin
      note_failure("core_reset never released after power-on");
    end
    repeat (4) @(negedge pclk);
    end_test("power_on");

    // random words on both joystick inputs
    repeat (64) begin
      @(negedge pclk);
      jjoy     = take_bits(8);
      rnd      = take_bits(6);
      joystick = rnd[5:0];
    end
    repeat (4) @(negedge pclk);
    end_test("joystick_capture");

    // switch toggles, a break, then a corrupted frame
    send_frame(code_scroll, 1'b1, 4'b0001, 1'b0, 1'b0);
    send_frame(code_f9, 1'b1, 4'b0011, 1'b0, 1'b0);
    send_frame(code_f10, 1'b1, 4'b0111, 1'b0, 1'b0);
    send_frame(code_f11, 1'b1, 4'b1111, 1'b0, 1'b0);
    send_frame(code_break, 1'b1, 4'b1111, 1'b0, 1'b0);
    send_frame(code_scroll, 1'b1, 4'b1111, 1'b0, 1'b0);
    send_frame(take_bits(8), 1'b0, 4'b1111, 1'b0, 1'b0);
    send_frame(code_f9, 1'b1, 4'b1101, 1'b0, 1'b0);
    end_test("switch_toggles");

    // f3 held, then the test button
    send_frame(code_f3, 1'b1, 4'b1101, 1'b1, 1'b0);
    repeat (20) @(negedge pclk);
    send_frame(code_break, 1'b1, 4'b1101, 1'b1, 1'b0);
    send_frame(code_f3, 1'b1, 4'b1101, 1'b0, 1'b0);
    jtest = 1'b0;
    repeat (12) @(negedge pclk);
    jtest = 1'b1;
    repeat (6) @(negedge pclk);
    end_test("reset_sources");

    // backspace alone, then the full chord, then the service button
    send_frame(code_bksp, 1'b1, 4'b1101, 1'b0, 1'b0);
    send_frame(code_lctrl, 1'b1, 4'b1101, 1'b0, 1'b0);
    send_frame(code_lalt, 1'b1, 4'b1101, 1'b0, 1'b0);
    send_frame(code_bksp, 1'b1, 4'b1101, 1'b0, 1'b1);
    jservice = 1'b0;
    repeat (12) @(negedge pclk);
    jservice = 1'b1;
    repeat (8) @(negedge pclk);
    end_test("reboot");

    $display("tests passed %0d, tests failed %0d, failed checks %0d",
             tests_pass, tests_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
